// ==== common/posit_params.svh ====
// Posit accumulator parameters
// Word format and internal accumulator widths

`ifndef POSIT_PARAMS_SVH
`define POSIT_PARAMS_SVH

`define POSIT_NBITS    32
`define POSIT_ES       3

// Fraction bits kept below the hidden bit in the running sum
`define ACC_FRAC_BITS  64

// Signed scale, regime times 2^ES plus exponent
`define SCALE_BITS     9

`define NAR_PATTERN    {1'b1, {(`POSIT_NBITS-1){1'b0}}}

`endif

// ==== common/posit_pkg.sv ====
// Posit accumulator types
// Vector types for posit words, scales and fractions, and the adder FSM states

`include "posit_params.svh"

package posit_pkg;

    typedef logic [`POSIT_NBITS-1:0] posit_t;

    // Read as signed, regime * 8 + exponent
    typedef logic [`SCALE_BITS-1:0] scale_t;

    typedef logic [`ACC_FRAC_BITS-1:0] acc_frac_t;

    // Carry, hidden bit and fraction
    typedef logic [`ACC_FRAC_BITS+1:0] sum_raw_t;

    typedef logic [7:0] shift_t;   // Alignment and normalization shifts

    typedef enum logic [1:0]
    {
        ADD_IDLE,
        ADD_SUM,
        ADD_NORM
    } add_state_t;

endpackage

// ==== common/posit_value_if.sv ====
// Posit value link
// One decoded or accumulated value with a valid pulse between pipeline blocks

interface posit_value_if;
    import posit_pkg::*;

    logic      valid;
    logic      sign;
    scale_t    scale;
    acc_frac_t fraction;   // Left aligned, hidden bit not stored
    logic      inf;        // NaR
    logic      zero;

    modport src (output valid, sign, scale, fraction, inf, zero);
    modport dst (input  valid, sign, scale, fraction, inf, zero);

endinterface

// ==== decode/posit_decode.sv ====
// Posit decoder
// Registers an accepted posit and splits it into sign, scale, fraction and flags

`include "posit_params.svh"

module posit_decode
(
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  posit_pkg::posit_t in1,
    posit_value_if.src        out
);
    import posit_pkg::*;

    localparam int BODY_BITS = `POSIT_NBITS - 1;
    localparam int TAIL_BITS = `POSIT_NBITS - 1 - `POSIT_ES;   // Room left below the exponent

    posit_t               word_q;
    logic                 valid_q;
    posit_t               abs_word;
    logic [BODY_BITS-1:0] body;
    logic [BODY_BITS-1:0] run_bits;
    logic [BODY_BITS-1:0] rem;
    shift_t               run;
    scale_t               k_val;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            valid_q <= 1'b0;
        else
            valid_q <= start;
    end

    always_ff @(posedge clk)
    begin
        if (start)
            word_q <= in1;
    end

    always_comb
    begin
        abs_word = word_q[`POSIT_NBITS-1] ? -word_q : word_q;
        body     = abs_word[BODY_BITS-1:0];

        // Regime run of ones becomes a run of zeros, then find the first one
        run_bits = body[BODY_BITS-1] ? ~body : body;
        run      = shift_t'(BODY_BITS);
        for (int i = 0; i < BODY_BITS; i++)
        begin
            if (run_bits[i])
                run = shift_t'(BODY_BITS - 1 - i);
        end

        // k = run - 1 for a run of ones, -run for a run of zeros
        if (body[BODY_BITS-1])
            k_val = scale_t'(run) - scale_t'(1);
        else
            k_val = scale_t'(0) - scale_t'(run);

        rem = body << (run + 8'd1);   // Drop regime and terminating bit
    end

    assign out.valid    = valid_q;
    assign out.sign     = word_q[`POSIT_NBITS-1];
    assign out.scale    = {k_val[`SCALE_BITS-`POSIT_ES-1:0], rem[BODY_BITS-1 -: `POSIT_ES]};
    assign out.fraction = {rem[TAIL_BITS-1:0], {(`ACC_FRAC_BITS-TAIL_BITS){1'b0}}};
    assign out.inf      = (word_q == `NAR_PATTERN);
    assign out.zero     = (word_q == '0);

    // One decoded value per accept, the align stage takes it in a single cycle
    a_valid_pulse: assert property (@(posedge clk) disable iff (rst)
        out.valid |=> !out.valid)
        else $error("decode valid held for more than one cycle");

endmodule

// ==== adder/posit_align_add.sv ====
// Posit align and add
// Adds a decoded operand into the wide accumulator over two FSM steps

`include "posit_params.svh"

module posit_align_add
(
    input  logic       clk,
    input  logic       rst,
    posit_value_if.dst in,
    posit_value_if.src out,
    output logic       ready,
    output logic       sticky
);
    import posit_pkg::*;

    localparam int MANT_BITS   = `ACC_FRAC_BITS + 1;   // Hidden bit and fraction
    localparam int RAW_BITS    = `ACC_FRAC_BITS + 2;
    localparam int SCALE_LIMIT = (`POSIT_NBITS - 2) << `POSIT_ES;   // maxpos scale
    localparam shift_t SHIFT_MAX = shift_t'(MANT_BITS + 1);

    add_state_t state;
    logic       valid_q;

    logic      op_sign, op_inf, op_zero;
    scale_t    op_scale;
    acc_frac_t op_frac;
    logic      acc_sign, acc_inf, acc_zero;
    scale_t    acc_scale;
    acc_frac_t acc_frac;

    logic                   op_big;
    logic                   hi_sign, hi_zero, lo_sign, lo_zero;
    scale_t                 hi_scale, lo_scale;
    acc_frac_t              hi_frac, lo_frac;
    logic signed [9:0]      scale_diff;
    shift_t                 align_shift;
    logic [2*MANT_BITS-1:0] lo_wide;
    sum_raw_t               sum_raw;

    sum_raw_t           s_raw;
    logic               s_sign, s_inf, s_sticky;
    scale_t             s_scale;
    shift_t             lead_zeros;
    sum_raw_t           norm_raw;
    logic signed [10:0] norm_scale;
    scale_t             sat_scale;
    logic               cancel;

    // Order by magnitude in ADD_SUM so the difference never goes negative
    always_comb
    begin
        op_big = acc_zero | (~op_zero & (($signed(op_scale) > $signed(acc_scale)) |
                 ((op_scale == acc_scale) & (op_frac >= acc_frac))));

        hi_sign  = op_big ? op_sign  : acc_sign;
        hi_zero  = op_big ? op_zero  : acc_zero;
        hi_scale = op_big ? op_scale : acc_scale;
        hi_frac  = op_big ? op_frac  : acc_frac;
        lo_sign  = op_big ? acc_sign  : op_sign;
        lo_zero  = op_big ? acc_zero  : op_zero;
        lo_scale = op_big ? acc_scale : op_scale;
        lo_frac  = op_big ? acc_frac  : op_frac;

        scale_diff  = $signed({hi_scale[`SCALE_BITS-1], hi_scale}) -
                      $signed({lo_scale[`SCALE_BITS-1], lo_scale});
        align_shift = (scale_diff > $signed({2'b00, SHIFT_MAX})) ? SHIFT_MAX :
                      shift_t'(scale_diff);
        lo_wide     = {~lo_zero, lo_frac, {MANT_BITS{1'b0}}} >> align_shift;

        if (hi_sign != lo_sign)   // Opposite signs subtract
            sum_raw = {1'b0, ~hi_zero, hi_frac} - {1'b0, lo_wide[2*MANT_BITS-1:MANT_BITS]};
        else
            sum_raw = {1'b0, ~hi_zero, hi_frac} + {1'b0, lo_wide[2*MANT_BITS-1:MANT_BITS]};
    end

    // Leading one moves to the top bit in ADD_NORM, then the scale follows
    always_comb
    begin
        lead_zeros = shift_t'(RAW_BITS);
        for (int i = 0; i < RAW_BITS; i++)
        begin
            if (s_raw[i])
                lead_zeros = shift_t'(RAW_BITS - 1 - i);
        end
        norm_raw   = s_raw << lead_zeros;
        norm_scale = $signed({{2{s_scale[`SCALE_BITS-1]}}, s_scale}) + 11'sd1 -
                     $signed({3'b000, lead_zeros});
        if (norm_scale > SCALE_LIMIT)
            sat_scale = scale_t'(SCALE_LIMIT);
        else if (norm_scale < -SCALE_LIMIT)
            sat_scale = scale_t'(-SCALE_LIMIT);
        else
            sat_scale = scale_t'(norm_scale);
        cancel = (s_raw == '0);
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state     <= ADD_IDLE;
            valid_q   <= 1'b0;
            sticky    <= 1'b0;
            acc_sign  <= 1'b0;
            acc_scale <= '0;
            acc_frac  <= '0;
            acc_inf   <= 1'b0;
            acc_zero  <= 1'b1;   // Sum starts at zero
        end
        else
        begin
            valid_q <= 1'b0;
            case (state)
                ADD_IDLE:
                begin
                    if (in.valid)
                        state <= ADD_SUM;
                end
                ADD_SUM:
                    state <= ADD_NORM;
                ADD_NORM:
                begin
                    state     <= ADD_IDLE;
                    valid_q   <= 1'b1;
                    sticky    <= s_sticky | ((lead_zeros == '0) & s_raw[0]);
                    acc_sign  <= cancel ? 1'b0 : s_sign;
                    acc_scale <= cancel ? '0 : sat_scale;
                    acc_frac  <= cancel ? '0 : norm_raw[RAW_BITS-2:1];
                    acc_inf   <= s_inf;   // NaR stays until reset
                    acc_zero  <= cancel & ~s_inf;   // NaR is never zero
                end
                default:
                    state <= ADD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == ADD_IDLE && in.valid)
        begin
            op_sign  <= in.sign;
            op_scale <= in.scale;
            op_frac  <= in.fraction;
            op_inf   <= in.inf;
            op_zero  <= in.zero;
        end
        if (state == ADD_SUM)
        begin
            s_raw    <= sum_raw;
            s_sign   <= hi_sign;
            s_scale  <= hi_scale;
            s_inf    <= op_inf | acc_inf;
            s_sticky <= |lo_wide[MANT_BITS-1:0];   // Shifted out during alignment
        end
    end

    assign ready        = (state == ADD_IDLE) & ~in.valid;
    assign out.valid    = valid_q;
    assign out.sign     = acc_sign;
    assign out.scale    = acc_scale;
    assign out.fraction = acc_frac;
    assign out.inf      = acc_inf;
    assign out.zero     = acc_zero;

    a_valid_idle: assert property (@(posedge clk) disable iff (rst)
        in.valid |-> state == ADD_IDLE)
        else $error("operand arrived while the adder was busy");

    // Busy for exactly the two adder steps, free again with the stored sum
    a_ready_seq: assert property (@(posedge clk) disable iff (rst)
        in.valid |-> !ready ##1 (!ready && state == ADD_SUM)
                     ##1 (!ready && state == ADD_NORM) ##1 (ready && out.valid))
        else $error("ready does not follow the adder sequence");

endmodule

// ==== encode/posit_round_pack.sv ====
// Posit round and pack
// Builds regime, exponent and fraction, rounds to nearest even and applies the sign

`include "posit_params.svh"

module posit_round_pack
(
    input  logic              clk,
    input  logic              rst,
    posit_value_if.dst        in,
    input  logic              sticky,
    output posit_pkg::posit_t result,
    output logic              inf,
    output logic              zero,
    output logic              done
);
    import posit_pkg::*;

    localparam int BODY_BITS = `POSIT_NBITS - 1;
    // Fill, terminator, exponent, fraction and room for the longest regime shift
    localparam int PACK_BITS = 2 + `POSIT_ES + `ACC_FRAC_BITS + `POSIT_NBITS - 2;

    scale_t               k_val;
    logic                 fill;
    shift_t               reg_shift;
    logic [PACK_BITS-1:0] pre_shift;
    logic [PACK_BITS-1:0] post_shift;

    logic                 valid1_q;
    logic [BODY_BITS-1:0] body_q;
    logic                 guard_q, sticky_q, sign_q, inf_q, zero_q;

    logic                 round_up;
    logic [BODY_BITS-1:0] rounded;
    posit_t               signed_word;

    // Stage one
    always_comb
    begin
        k_val = scale_t'($signed(in.scale) >>> `POSIT_ES);
        fill  = ~in.scale[`SCALE_BITS-1];                 // Ones for k >= 0
        reg_shift = fill ? shift_t'(k_val) : shift_t'(~k_val);   // Run length minus one
        pre_shift = {fill, ~fill, in.scale[`POSIT_ES-1:0], in.fraction,
                     {(`POSIT_NBITS-2){1'b0}}};
        post_shift = $signed(pre_shift) >>> reg_shift;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            valid1_q <= 1'b0;
        else
            valid1_q <= in.valid;
    end

    always_ff @(posedge clk)
    begin
        if (in.valid)
        begin
            body_q   <= post_shift[PACK_BITS-1 -: BODY_BITS];
            guard_q  <= post_shift[PACK_BITS-1-BODY_BITS];
            sticky_q <= sticky | (|post_shift[PACK_BITS-2-BODY_BITS:0]);
            sign_q   <= in.sign;
            inf_q    <= in.inf;
            zero_q   <= in.zero;
        end
    end

    // Stage two rounds without carrying maxpos into NaR
    always_comb
    begin
        round_up    = guard_q & (sticky_q | body_q[0]) & ~(&body_q);
        rounded     = body_q + BODY_BITS'(round_up);
        signed_word = sign_q ? -{1'b0, rounded} : {1'b0, rounded};
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            result <= '0;
            inf    <= 1'b0;
            zero   <= 1'b1;
            done   <= 1'b0;
        end
        else
        begin
            done <= valid1_q;
            if (valid1_q)
            begin
                result <= inf_q ? `NAR_PATTERN : (zero_q ? '0 : signed_word);
                inf    <= inf_q;
                zero   <= zero_q;
            end
        end
    end

    a_flags_exclusive: assert property (@(posedge clk) disable iff (rst)
        done |-> !(inf && zero))
        else $error("inf and zero both set on done");

endmodule

// ==== hdl/posit_accum_top.sv ====
// Posit accumulator top level
// Decode, align-add and round-pack stages around a running posit sum

module posit_accum_top
(
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  posit_pkg::posit_t in1,
    output logic              ready,
    output posit_pkg::posit_t result,
    output logic              inf,
    output logic              zero,
    output logic              done
);

    logic accept;
    logic sticky;   // Bits lost while aligning the last operand

    posit_value_if dec_if ();
    posit_value_if sum_if ();

    // Start while busy is dropped
    assign accept = start & ready;

    posit_decode u_decode
    (
        .clk   (clk),
        .rst   (rst),
        .start (accept),
        .in1   (in1),
        .out   (dec_if.src)
    );

    posit_align_add u_align_add
    (
        .clk    (clk),
        .rst    (rst),
        .in     (dec_if.dst),
        .out    (sum_if.src),
        .ready  (ready),
        .sticky (sticky)
    );

    posit_round_pack u_round_pack
    (
        .clk    (clk),
        .rst    (rst),
        .in     (sum_if.dst),
        .sticky (sticky),
        .result (result),
        .inf    (inf),
        .zero   (zero),
        .done   (done)
    );

endmodule

// ==== tests/posit_model.svh ====
// Posit reference model for the accumulator testbench
// Encodes signed dyadic values into 32-bit posits with es = 3, round to nearest even

`ifndef POSIT_MODEL_SVH
`define POSIT_MODEL_SVH

localparam int FIX_SHIFT = 40;   // Model sums are kept in units of 2^-40

// Value is mag * 2^exp2
function automatic logic [31:0] encode_dyadic(input logic neg, input logic [63:0] mag,
                                              input int exp2);
    logic [127:0] bits;
    logic [30:0]  body;
    logic [31:0]  word;
    logic         guard;
    logic         rest;
    int           msb;
    int           scale;
    int           k;
    int           e;
    int           pos;

    if (mag == '0)
        return 32'h0;
    msb = 63;
    while (!mag[msb])
        msb--;
    scale = msb + exp2;
    k     = (scale >= 0) ? scale / 8 : -((7 - scale) / 8);   // Floor division
    e     = scale - 8 * k;

    bits = '0;
    pos  = 127;
    if (k >= 0)
    begin
        for (int i = 0; i <= k; i++)
        begin
            bits[pos] = 1'b1;
            pos--;
        end
        pos--;   // Terminating zero
    end
    else
    begin
        pos       = pos + k;
        bits[pos] = 1'b1;
        pos--;
    end
    for (int i = 2; i >= 0; i--)
    begin
        bits[pos] = e[i];
        pos--;
    end
    for (int i = msb - 1; i >= 0; i--)
    begin
        bits[pos] = mag[i];
        pos--;
    end

    body  = bits[127:97];
    guard = bits[96];
    rest  = |bits[95:0];
    body  = body + 31'(guard & (rest | body[0]));
    word  = {1'b0, body};
    return neg ? -word : word;
endfunction

// Signed fixed point value in units of 2^-40
function automatic logic [31:0] encode_fixed(input longint v);
    logic   neg;
    longint mag;

    neg = (v < 0);
    mag = neg ? -v : v;
    return encode_dyadic(neg, 64'(mag), -FIX_SHIFT);
endfunction

function automatic logic [31:0] encode_int(input int v);
    return encode_fixed(longint'(v) <<< FIX_SHIFT);
endfunction

`endif

// ==== tests/tb_posit_accum.sv ====
// Posit accumulator testbench
// Integer sums, cancellation, rounding, NaR and busy starts checked against a posit model

`include "posit_params.svh"

module tb_posit_accum;
    import posit_pkg::*;

    `include "posit_model.svh"

    localparam int WAIT_LIMIT = 50;   // Cycles allowed for ready or done

    logic   clk;
    logic   rst;
    logic   start;
    posit_t in1;
    logic   ready;
    posit_t result;
    logic   inf;
    logic   zero;
    logic   done;
    logic   accepted;

    integer seed;
    int     err_cnt;
    int     tests_run;
    int     tests_passed;
    int     accept_cnt;
    int     done_cnt;

    longint model_sum;   // Units of 2^-40
    logic   model_nar;
    posit_t exp_result;
    logic   exp_inf;
    logic   exp_zero;

    posit_accum_top u_dut
    (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .in1    (in1),
        .ready  (ready),
        .result (result),
        .inf    (inf),
        .zero   (zero),
        .done   (done)
    );

    assign accepted = start & ready;

    always #2 clk = ~clk;

    always @(negedge clk)
    begin
        if (!rst)
        begin
            if (accepted)
                accept_cnt++;
            if (done)
                done_cnt++;
        end
    end

    task automatic note_value_error(input string name, input logic [31:0] expected,
                                    input logic [31:0] actual);
        $display("ERR t=%0t %s expected 0x%08h got 0x%08h", $time, name, expected, actual);
        err_cnt++;
    endtask

    task automatic note_failure(input string what);
        $display("t=%0t %s", $time, what);
        err_cnt++;
    endtask

    a_done_latency: assert property (@(posedge clk) disable iff (rst)
        done == $past(accepted, 6))
        else note_value_error("done", {31'b0, !$sampled(done)}, {31'b0, $sampled(done)});

    a_result: assert property (@(posedge clk) disable iff (rst)
        done |-> result == exp_result)
        else note_value_error("result", $sampled(exp_result), $sampled(result));

    a_inf: assert property (@(posedge clk) disable iff (rst)
        done |-> inf == exp_inf)
        else note_value_error("inf", {31'b0, $sampled(exp_inf)}, {31'b0, $sampled(inf)});

    a_zero: assert property (@(posedge clk) disable iff (rst)
        done |-> zero == exp_zero)
        else note_value_error("zero", {31'b0, $sampled(exp_zero)}, {31'b0, $sampled(zero)});

    task automatic stop_on_timeout(input string what);
        $display("timeout: %s", what);
        $display("RESULT: FAIL");
        $finish;
    endtask

    task automatic apply_reset;
        @(posedge clk);
        rst   <= 1'b1;
        start <= 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        model_sum  = 0;
        model_nar  = 1'b0;
        exp_result = '0;
        exp_inf    = 1'b0;
        exp_zero   = 1'b1;
        @(negedge clk);
    endtask

    task automatic check_reset_state;
        assert (ready === 1'b1) else note_value_error("ready", 32'd1, {31'b0, ready});
        assert (done === 1'b0) else note_value_error("done", 32'd0, {31'b0, done});
        assert (zero === 1'b1) else note_value_error("zero", 32'd1, {31'b0, zero});
        assert (inf === 1'b0) else note_value_error("inf", 32'd0, {31'b0, inf});
        assert (result === '0) else note_value_error("result", 32'd0, result);
    endtask

    // One operand through the full handshake, poke raises start again while busy
    task automatic send_operand(input posit_t word, input longint delta, input logic is_nar,
                                input logic poke);
        int waited;

        waited = 0;
        @(negedge clk);
        while (!ready)
        begin
            if (waited >= WAIT_LIMIT)
                stop_on_timeout("ready never rose for the next operand");
            waited++;
            @(negedge clk);
        end
        @(posedge clk);
        start <= 1'b1;
        in1   <= word;
        @(posedge clk);   // Accepting edge
        start <= 1'b0;
        if (is_nar)
            model_nar = 1'b1;
        else
            model_sum = model_sum + delta;
        exp_result = model_nar ? `NAR_PATTERN : encode_fixed(model_sum);
        exp_inf    = model_nar;
        exp_zero   = !model_nar && (model_sum == 0);

        if (poke)
        begin
            @(posedge clk);
            start <= 1'b1;
            in1   <= encode_int(50);
            @(negedge clk);
            if (ready)
                note_failure("ready was high while the accumulator was busy");
            @(posedge clk);
            start <= 1'b0;
        end

        waited = 0;
        @(negedge clk);
        while (!done)
        begin
            if (waited >= WAIT_LIMIT)
                stop_on_timeout("done never followed an accepted operand");
            waited++;
            @(negedge clk);
        end
        @(posedge clk);
        @(negedge clk);   // Let the checks on the done edge finish
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (err_cnt == errs_before)
        begin
            tests_passed++;
            $display("test %s: passed", name);
        end
        else
            $display("test %s: failed with %0d errors", name, err_cnt - errs_before);
    endtask

    initial
    begin : main
        int     errs_before;
        int     value;
        int     accepts_before;
        posit_t x_word;

        clk          = 1'b0;
        rst          = 1'b1;
        start        = 1'b0;
        in1          = '0;
        seed         = 32'hc683ac11;
        err_cnt      = 0;
        tests_run    = 0;
        tests_passed = 0;
        accept_cnt   = 0;
        done_cnt     = 0;
        apply_reset();

        errs_before = err_cnt;
        check_reset_state();
        report_test("reset state", errs_before);

        errs_before = err_cnt;
        for (int i = 0; i < 20; i++)
        begin
            value = 1 + int'($unsigned($random(seed)) % 100);
            send_operand(encode_int(value), longint'(value) <<< FIX_SHIFT, 1'b0, 1'b0);
        end
        report_test("integer sums", errs_before);

        apply_reset();
        errs_before = err_cnt;
        value  = 1 + int'($unsigned($random(seed)) % 100);
        x_word = encode_int(value);
        send_operand(x_word, longint'(value) <<< FIX_SHIFT, 1'b0, 1'b0);
        send_operand(-x_word, -(longint'(value) <<< FIX_SHIFT), 1'b0, 1'b0);
        assert (zero === 1'b1) else note_value_error("zero", 32'd1, {31'b0, zero});
        assert (result === '0) else note_value_error("result", 32'd0, result);
        value = 1 + int'($unsigned($random(seed)) % 100);
        send_operand(encode_int(value), longint'(value) <<< FIX_SHIFT, 1'b0, 1'b0);
        assert (result === encode_int(value))
            else note_value_error("result", encode_int(value), result);
        report_test("cancellation", errs_before);

        // 2^-40 steps stay below the result ulp but build up in the wide fraction
        apply_reset();
        errs_before = err_cnt;
        send_operand(encode_int(1), longint'(1) <<< FIX_SHIFT, 1'b0, 1'b0);
        for (int i = 0; i < 8193; i++)
        begin
            send_operand(encode_dyadic(1'b0, 64'd1, -40), 1, 1'b0, 1'b0);
            if (i == 0 || i == 8191)
                assert (result === encode_int(1))
                    else note_value_error("result", encode_int(1), result);
        end
        x_word = encode_fixed((longint'(1) <<< 40) + (longint'(1) <<< 14));
        assert (result === x_word) else note_value_error("result", x_word, result);
        report_test("small addends", errs_before);

        apply_reset();
        errs_before = err_cnt;
        send_operand(encode_int(5), longint'(5) <<< FIX_SHIFT, 1'b0, 1'b0);
        send_operand(`NAR_PATTERN, 0, 1'b1, 1'b0);
        for (int i = 0; i < 3; i++)
            send_operand(encode_int(i + 2), longint'(i + 2) <<< FIX_SHIFT, 1'b0, 1'b0);
        assert (inf === 1'b1) else note_value_error("inf", 32'd1, {31'b0, inf});
        assert (result === `NAR_PATTERN) else note_value_error("result", `NAR_PATTERN, result);
        apply_reset();
        check_reset_state();
        report_test("nar", errs_before);

        apply_reset();
        errs_before    = err_cnt;
        accepts_before = accept_cnt;
        for (int i = 0; i < 6; i++)
        begin
            value = 1 + int'($unsigned($random(seed)) % 100);
            send_operand(encode_int(value), longint'(value) <<< FIX_SHIFT, 1'b0, 1'b1);
        end
        assert (accept_cnt - accepts_before == 6)
            else note_value_error("accept_count", 32'd6, 32'(accept_cnt - accepts_before));
        assert (done_cnt == accept_cnt)
            else note_value_error("done_count", 32'(accept_cnt), 32'(done_cnt));
        report_test("busy start", errs_before);

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_passed, tests_run - tests_passed, err_cnt);
        if (err_cnt == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+common
+incdir+tests
common/posit_pkg.sv
common/posit_value_if.sv
decode/posit_decode.sv
adder/posit_align_add.sv
encode/posit_round_pack.sv
hdl/posit_accum_top.sv
tests/tb_posit_accum.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the posit accumulator testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_posit_accum \
    -Mdir obj_dir -o sim_posit_accum > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_posit_accum > sim.log 2>&1 || echo "simulator returned an error" >> sim.log
cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1
grep -q "RESULT: PASS" sim.log || exit 1
exit 0
